/* compile.f */
+incdir+dv
hw/cheat_pkg.sv
hw/cheat_prog_rom.sv
hw/cheat_port_regs.sv
hw/cheat_sdram_arb.sv
hw/cheat_top.sv
dv/cheat_tb.sv

/* dv/cheat_tests.svh */
task automatic port_write(input cheat_pkg::port_id_t id, input cheat_pkg::port_data_t d,
                          input logic constant = 1'b0);
    @(posedge clk);
    #1 port_id = id;
    out_data = d;
    wr_stb   = !constant;
    k_wr_stb = constant;
    @(posedge clk);
    #1 wr_stb = 1'b0;
    k_wr_stb = 1'b0;
endtask

// in_data is registered on the strobe edge
task automatic port_read(input cheat_pkg::port_id_t id, output cheat_pkg::port_data_t d);
    @(posedge clk);
    #1 port_id = id;
    rd_stb = 1'b1;
    @(posedge clk);
    #1 rd_stb = 1'b0;
    d = in_data;
endtask

task automatic wait_cheat_idle();
    cheat_pkg::port_data_t st;
    int                    t;
    t = 0;
    do begin
        port_read(8'h80, st);
        t++;
    end while (st[6] && t < 60);
    assert (!st[6]) else stop_run("cheat access never finished");
endtask

task automatic game_access(input logic wr, input cheat_pkg::sdram_addr_t a,
                           input cheat_pkg::sdram_data_t d, input cheat_pkg::sdram_mask_t m,
                           output cheat_pkg::sdram_data_t q);
    int t;
    @(posedge clk);
    #1 game_req = {a, !wr, wr, d, m};
    game_active = 1'b1;
    t = 0;
    do begin
        @(negedge clk);
        t++;
    end while (!game_rsp.ack && t < 40);
    assert (game_rsp.ack) else stop_run("game request got no ack");
    @(posedge clk);
    #1 game_req = '0;
    t = 0;
    do begin
        @(negedge clk);
        t++;
    end while (!game_rsp.rdy && t < 20);
    assert (game_rsp.rdy && game_rsp.dst) else stop_run("game access never ended");
    q = bank_data;
    @(posedge clk);
    game_active = 1'b0;
endtask

task automatic cheat_setup(input cheat_pkg::sdram_addr_t a, input cheat_pkg::sdram_data_t d,
                           input cheat_pkg::sdram_mask_t m);
    port_write(8'h00, a[7:0]);
    port_write(8'h01, a[15:8]);
    port_write(8'h02, {2'b00, a[21:16]});
    port_write(8'h03, d[7:0]);
    port_write(8'h04, d[15:8]);
    port_write(8'h05, {6'd0, m});
endtask

task automatic cheat_read_word(output cheat_pkg::sdram_data_t q);
    cheat_pkg::port_data_t lo;
    cheat_pkg::port_data_t hi;
    port_read(8'h06, lo);
    port_read(8'h07, hi);
    q = {hi, lo};
endtask

task automatic test_prog_load();
    cheat_pkg::instr_t exp [16];
    logic [7:0]        b [3];
    @(posedge clk);
    #1 prog_en = 1'b1;
    @(posedge clk);
    #1 prog_en = 1'b0;
    for (int w = 0; w < 16; w++) begin
        for (int k = 0; k < 3; k++) begin
            b[k] = 8'(rand_bits(8));
            prog_wr   = 1'b1;
            prog_data = b[k];
            @(posedge clk);
            #1 prog_wr = 1'b0;
        end
        exp[w] = {b[2][1:0], b[1], b[0]};
    end
    for (int w = 0; w < 16; w++) begin
        iaddr = w[prog_aw-1:0];
        @(posedge clk);
        #1 check_val("prog_load", exp[w], idata);
    end
    prog_en = 1'b1;   // restart the loader at word 0
    @(posedge clk);
    #1 prog_en = 1'b0;
    for (int k = 0; k < 3; k++) begin
        b[k] = 8'(rand_bits(8));
        prog_wr   = 1'b1;
        prog_data = b[k];
        @(posedge clk);
        #1 prog_wr = 1'b0;
    end
    iaddr = '0;
    @(posedge clk);
    #1 check_val("prog_restart", {b[2][1:0], b[1], b[0]}, idata);
    iaddr = 1;
    @(posedge clk);
    #1 check_val("prog_restart_keep", exp[1], idata);
endtask

task automatic test_ports();
    cheat_pkg::port_data_t v [6];
    cheat_pkg::port_data_t got;
    for (int p = 0; p < 6; p++) begin
        v[p] = 8'(rand_bits(8));
        port_write(p[7:0], v[p]);
    end
    for (int p = 0; p < 6; p++) begin
        port_read(p[7:0], got);
        check_val("port_readback", v[p], got);
    end
    flags = rand_bits(32);
    for (int p = 0; p < 4; p++) begin
        port_read(8'h10 + p[7:0], got);
        check_val("flag_bytes", flags[p*8 +: 8], got);
    end
    port_write(8'h06, 8'h01);
    check_val("led_on", 1, led);
    port_write(8'h06, 8'h00);
    check_val("led_off", 0, led);
    port_read(8'h80, got);
    check_val("status_lvbl_high", 8'h20, got);
    lvbl = 1'b0;
    port_read(8'h80, got);
    check_val("status_lvbl_low", 8'h00, got);
    lvbl = 1'b1;
endtask

task automatic test_game_path();
    cheat_pkg::sdram_data_t q;
    game_access(1'b1, 22'h01_2345, 16'hbeef, 2'b01, q);
    game_access(1'b0, 22'h01_2345, '0, '0, q);
    check_val("game_masked_write", 16'h23ef, q);   // high byte keeps the fill
    game_access(1'b0, 22'h2a_5678, '0, '0, q);
    check_val("game_unwritten", 16'h5678, q);
endtask

task automatic test_cheat_access();
    cheat_pkg::sdram_data_t d;
    cheat_pkg::sdram_data_t q;
    int                     acks;
    d = 16'(rand_bits(16));
    cheat_setup(22'h15_0a0c, d, 2'b10);
    port_write(8'hc0, 8'h00);
    wait_cheat_idle();
    acks = cheat_acks;
    port_write(8'h80, 8'h00);
    wait_cheat_idle();
    check_val("cheat_read_acked", acks + 1, cheat_acks);
    cheat_read_word(q);
    check_val("cheat_read", {d[15:8], 8'h0c}, q);
    game_access(1'b0, 22'h15_0a0c, '0, '0, q);
    check_val("game_sees_cheat_write", {d[15:8], 8'h0c}, q);
endtask

task automatic test_contention();
    cheat_pkg::sdram_data_t q;
    int                     acks_before;
    cheat_setup(22'h3f_1111, '0, 2'b00);
    acks_before = cheat_acks;
    fork
        port_write(8'h80, 8'h00);
        begin
            @(posedge clk);
            game_access(1'b0, 22'h01_2345, '0, '0, q);
        end
    join
    check_val("contention_game_data", 16'h23ef, q);
    check_val("contention_game_first", acks_before, cheat_acks);
    wait_cheat_idle();
    check_val("contention_cheat_done", acks_before + 1, cheat_acks);
    cheat_read_word(q);
    check_val("contention_cheat_data", 16'h1111, q);
endtask

task automatic test_vblank_irq();
    int t;
    @(posedge clk);
    #1 iack = 1'b1;   // irq still pending from the status test
    @(posedge clk);
    #1 iack = 1'b0;
    check_val("irq_idle", 0, irq);
    for (int e = 0; e < 3; e++) begin
        @(posedge clk);
        #1 lvbl = 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!irq && t < 5);
        assert (irq) else stop_run("irq did not rise after vertical blank");
        @(posedge clk);
        #1 iack = 1'b1;
        @(posedge clk);
        #1 iack = 1'b0;
        check_val("irq_cleared", 0, irq);
        lvbl = 1'b1;
        repeat (2) @(posedge clk);
    end
endtask

task automatic vblank_edge();
    @(posedge clk);
    #1 lvbl = 1'b0;
    repeat (2) @(posedge clk);
    #1 lvbl = 1'b1;
    repeat (2) @(posedge clk);
endtask

task automatic test_watchdog();
    int t;
    port_write(8'h40, 8'h00, 1'b1);   // kick clears earlier edges
    port_write(8'h06, 8'h01);
    check_val("wdog_led_set", 1, led);
    for (int e = 0; e < 7; e++) vblank_edge();
    check_val("wdog_early", 0, rst_pulses);
    vblank_edge();
    t = 0;
    while (rst_pulses == 0 && t < 10) begin
        @(posedge clk);
        t++;
    end
    check_val("wdog_reset", 1, rst_pulses);
    repeat (3) @(posedge clk);
    check_val("wdog_led_cleared", 0, led);
    for (int e = 0; e < 12; e++) begin
        vblank_edge();
        port_write(8'h7f, 8'h00, e[0]);
    end
    check_val("wdog_kicked", 1, rst_pulses);
endtask

/* dv/cheat_tb.sv */
`timescale 1ns/100ps

module cheat_tb;

    localparam int          prog_aw   = 10;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;  // x^32+x^22+x^2+x+1

    logic                   clk;
    logic                   prst;
    logic                   lvbl;
    logic [31:0]            flags;
    cheat_pkg::sdram_req_t  game_req;
    cheat_pkg::sdram_rsp_t  game_rsp;
    cheat_pkg::sdram_req_t  bank_req;
    cheat_pkg::sdram_rsp_t  bank_rsp;
    cheat_pkg::sdram_data_t bank_data;
    cheat_pkg::port_id_t    port_id;
    cheat_pkg::port_data_t  out_data;
    logic                   wr_stb;
    logic                   k_wr_stb;
    logic                   rd_stb;
    cheat_pkg::port_data_t  in_data;
    logic                   iack;
    logic                   irq;
    logic                   cpu_rst;
    logic [prog_aw-1:0]     iaddr;
    cheat_pkg::instr_t      idata;
    logic                   prog_en;
    logic                   prog_wr;
    cheat_pkg::port_data_t  prog_data;
    logic                   led;

    logic [31:0] lfsr_q = 32'h1f82_eadc;
    int          cheat_acks = 0;   // acks seen on the cheat side
    int          rst_pulses = 0;   // cpu_rst rising edges after prst
    logic        rst_last = 1'b0;
    logic        game_active = 1'b0;   // game request in flight
    cheat_pkg::sdram_data_t bank_mem [cheat_pkg::sdram_addr_t];

    cheat_top #(
        .prog_aw (prog_aw)
    ) dut_i (
        .clk (clk), .prst (prst), .lvbl (lvbl), .flags (flags),
        .game_req (game_req), .game_rsp (game_rsp),
        .bank_req (bank_req), .bank_rsp (bank_rsp), .bank_data (bank_data),
        .port_id (port_id), .out_data (out_data), .wr_stb (wr_stb),
        .k_wr_stb (k_wr_stb), .rd_stb (rd_stb), .in_data (in_data),
        .iack (iack), .irq (irq), .cpu_rst (cpu_rst),
        .iaddr (iaddr), .idata (idata),
        .prog_en (prog_en), .prog_wr (prog_wr), .prog_data (prog_data),
        .led (led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ lfsr_taps : lfsr_q >> 1;
        end
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, got);
            stop_run("value mismatch");
        end
    endtask

    // bank model acks 1 to 3 cycles after a request and ends it two cycles later
    initial begin
        cheat_pkg::sdram_req_t req;
        int                    n;
        bank_rsp  = '0;
        bank_data = '0;
        forever begin
            @(negedge clk);
            if (bank_req.rd || bank_req.wr) begin
                req = bank_req;
                n   = 1 + int'(rand_bits(2) % 3);
                repeat (n) @(posedge clk);
                #1 bank_rsp.ack = 1'b1;
                if (req.wr) begin
                    bank_data = bank_mem.exists(req.addr) ? bank_mem[req.addr] : req.addr[15:0];
                    if (req.din_m[0]) bank_data[7:0]  = req.din[7:0];
                    if (req.din_m[1]) bank_data[15:8] = req.din[15:8];
                    bank_mem[req.addr] = bank_data;
                end
                @(posedge clk);
                #1 bank_rsp.ack = 1'b0;
                @(posedge clk);
                #1 bank_rsp = 3'b011;
                bank_data = bank_mem.exists(req.addr) ? bank_mem[req.addr] : req.addr[15:0];
                @(posedge clk);
                #1 bank_rsp = '0;
            end
        end
    end

    // responses must only reach the current owner
    always @(negedge clk) begin
        assert (!(game_active && dut_i.cheat_rsp != 0) &&
                (game_active || game_rsp == 0)) else
            stop_run("a response reached the side that does not own the bank");
        if (dut_i.cheat_rsp.ack) cheat_acks++;
        if (cpu_rst && !rst_last && !prst) rst_pulses++;
        rst_last = cpu_rst;
    end

    `include "cheat_tests.svh"

    initial begin
        #2_000_000;
        stop_run("simulation did not finish in time");
    end

    initial begin
        prst      = 1'b1;
        lvbl      = 1'b1;
        flags     = '0;
        game_req  = '0;
        port_id   = '0;
        out_data  = '0;
        wr_stb    = 1'b0;
        k_wr_stb  = 1'b0;
        rd_stb    = 1'b0;
        iack      = 1'b0;
        iaddr     = '0;
        prog_en   = 1'b0;
        prog_wr   = 1'b0;
        prog_data = '0;
        repeat (4) @(posedge clk);
        #1 prst = 1'b0;
        repeat (2) @(posedge clk);
        test_prog_load();
        test_ports();
        test_game_path();
        test_cheat_access();
        test_contention();
        test_vblank_irq();
        test_watchdog();
        $display("all tests passed");
        $finish;
    end

endmodule

/* hw/cheat_pkg.sv */
package cheat_pkg;

    // widths with a meaning of their own
    typedef logic [21:0] sdram_addr_t;  // word address
    typedef logic [15:0] sdram_data_t;
    typedef logic [ 1:0] sdram_mask_t;  // byte enables for writes
    typedef logic [ 7:0] port_id_t;
    typedef logic [ 7:0] port_data_t;
    typedef logic [17:0] instr_t;

    // one access towards the bank, 42 bits
    typedef struct packed {
        sdram_addr_t addr;
        logic        rd;
        logic        wr;
        sdram_data_t din;
        sdram_mask_t din_m;
    } sdram_req_t;

    // bank answer, all single-cycle strobes
    typedef struct packed {
        logic ack;
        logic dst;   // read data valid
        logic rdy;   // access done
    } sdram_rsp_t;

    typedef enum logic [1:0] {
        idle,
        game_busy,
        cheat_busy
    } arb_state_t;

    // controller port map
    localparam port_id_t port_addr0     = 8'h00;  // address lsb
    localparam port_id_t port_addr1     = 8'h01;
    localparam port_id_t port_addr2     = 8'h02;
    localparam port_id_t port_din_lo    = 8'h03;
    localparam port_id_t port_din_hi    = 8'h04;
    localparam port_id_t port_mask      = 8'h05;  // last plain byte register
    localparam port_id_t port_led       = 8'h06;  // write side
    localparam port_id_t port_rd_lo     = 8'h06;  // read side
    localparam port_id_t port_rd_hi     = 8'h07;
    localparam port_id_t port_flag_base = 8'h10;  // 0x10..0x13
    localparam port_id_t port_kick      = 8'h40;  // 0x40..0x7f
    localparam port_id_t port_sdram_rd  = 8'h80;  // 0x80..0xbf
    localparam port_id_t port_sdram_wr  = 8'hc0;  // 0xc0..0xff

    // status byte layout
    localparam int st_owner = 7;
    localparam int st_busy  = 6;
    localparam int st_lvbl  = 5;

endpackage

/* hw/cheat_port_regs.sv */
`timescale 1ns/100ps

module cheat_port_regs (
    input  logic                   clk,
    input  logic                   prst,
    input  logic                   lvbl,
    input  logic [31:0]            flags,
    // controller port bus
    input  cheat_pkg::port_id_t    port_id,
    input  cheat_pkg::port_data_t  out_data,
    input  logic                   wr_stb,
    input  logic                   k_wr_stb,
    input  logic                   rd_stb,
    input  logic                   iack,
    output cheat_pkg::port_data_t  in_data,
    output logic                   irq,
    output logic                   led,
    output logic                   cpu_rst,
    // cheat side of the arbiter
    output cheat_pkg::sdram_req_t  cheat_req,
    input  cheat_pkg::sdram_rsp_t  cheat_rsp,
    input  cheat_pkg::sdram_data_t rd_data,
    input  logic                   owner_cheat
);

    cheat_pkg::port_data_t port_q [8];

    logic       wr_any;
    logic       req_q;       // pending request to the arbiter
    logic       req_wr_q;    // direction of that request
    logic       busy_q;      // between ack and rdy
    logic       lvbl_last;
    logic       lvbl_fall;
    logic [3:0] wdog;
    logic       core_rst;    // external reset or watchdog
    logic       kick;
    logic       sdram_cmd;
    cheat_pkg::port_data_t status;

    assign wr_any    = wr_stb | k_wr_stb;
    assign lvbl_fall = lvbl_last & ~lvbl;
    assign core_rst  = prst | cpu_rst;
    assign kick      = wr_any && port_id[7:6] == cheat_pkg::port_kick[7:6];
    assign sdram_cmd = wr_any && port_id[7];

    // plain byte registers, read data lands in 6 and 7
    always_ff @(posedge clk) begin
        if (wr_any && port_id <= cheat_pkg::port_mask) begin
            port_q[port_id[2:0]] <= out_data;
        end
        if (cheat_rsp.dst) begin   // already gated to the cheat owner
            port_q[cheat_pkg::port_rd_lo[2:0]] <= rd_data[7:0];
            port_q[cheat_pkg::port_rd_hi[2:0]] <= rd_data[15:8];
        end
    end

    always_comb begin
        cheat_req.addr  = {port_q[cheat_pkg::port_addr2[2:0]][5:0],
                           port_q[cheat_pkg::port_addr1[2:0]],
                           port_q[cheat_pkg::port_addr0[2:0]]};
        cheat_req.rd    = req_q & ~req_wr_q;
        cheat_req.wr    = req_q &  req_wr_q;
        cheat_req.din   = {port_q[cheat_pkg::port_din_hi[2:0]],
                           port_q[cheat_pkg::port_din_lo[2:0]]};
        cheat_req.din_m = port_q[cheat_pkg::port_mask[2:0]][1:0];
    end

    // request stays up until the bank takes it
    // only prst clears it, the arbiter may be mid-access on a watchdog reset
    always_ff @(posedge clk) begin
        if (prst) begin
            req_q    <= 1'b0;
            req_wr_q <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            if (cheat_rsp.ack) req_q <= 1'b0;
            if (sdram_cmd) begin
                req_q    <= 1'b1;
                req_wr_q <= port_id[7:6] == cheat_pkg::port_sdram_wr[7:6];
            end
            if (cheat_rsp.ack)      busy_q <= 1'b1;
            else if (cheat_rsp.rdy) busy_q <= 1'b0;
        end
    end

    // vertical blank edge, irq and watchdog
    always_ff @(posedge clk) begin
        if (core_rst) begin
            lvbl_last <= 1'b0;
            irq       <= 1'b0;
            wdog      <= 4'd0;
        end else begin
            lvbl_last <= lvbl;
            if (lvbl_fall)  irq <= 1'b1;
            else if (iack)  irq <= 1'b0;
            if (kick)           wdog <= 4'd0;
            else if (lvbl_fall) wdog <= wdog + 1'd1;
        end
    end

    always_ff @(posedge clk) begin
        cpu_rst <= prst | wdog[3];   // count of 8 restarts the core
    end

    always_ff @(posedge clk) begin
        if (core_rst) begin
            led <= 1'b0;
        end else if (wr_any && port_id == cheat_pkg::port_led) begin
            led <= out_data[0];
        end
    end

    always_comb begin
        status                    = '0;
        status[cheat_pkg::st_owner] = owner_cheat;
        status[cheat_pkg::st_busy]  = req_q | busy_q;  // busy until rdy
        status[cheat_pkg::st_lvbl]  = lvbl;
    end

    // read mux, registered on the strobe
    always_ff @(posedge clk) begin
        if (core_rst) begin
            in_data <= '0;
        end else if (rd_stb) begin
            if (port_id < 8'd8)
                in_data <= port_q[port_id[2:0]];
            else if (port_id[7:2] == cheat_pkg::port_flag_base[7:2])
                in_data <= flags[port_id[1:0]*8 +: 8];
            else if (port_id[7])
                in_data <= status;
            else
                in_data <= '0;   // kick range and holes
        end
    end

endmodule

/* hw/cheat_prog_rom.sv */
`timescale 1ns/100ps

module cheat_prog_rom #(
    parameter int prog_aw = 10
) (
    input  logic                  clk,
    input  logic                  prst,
    // byte loader
    input  logic                  prog_en,
    input  logic                  prog_wr,
    input  cheat_pkg::port_data_t prog_data,
    // fetch side
    input  logic [prog_aw-1:0]    iaddr,
    output cheat_pkg::instr_t     idata
);

    cheat_pkg::instr_t  mem [2**prog_aw];

    logic [prog_aw-1:0] ld_addr;   // next word to fill
    logic [1:0]         phase;     // byte position within the word
    logic [15:0]        hold;      // low two bytes waiting for the third
    logic               byte_ok;
    logic               word_wr;

    // prog_en wins over a byte arriving in the same cycle
    assign byte_ok = prog_wr && !prog_en;
    assign word_wr = byte_ok && phase == 2'd2;

    always_ff @(posedge clk) begin
        if (prst || prog_en) begin
            ld_addr <= '0;
            phase   <= 2'd0;
        end else if (byte_ok) begin
            if (phase == 2'd2) begin
                phase   <= 2'd0;
                ld_addr <= ld_addr + 1'd1;
            end else begin
                phase <= phase + 1'd1;
            end
        end
    end

    // first two bytes of a word
    always_ff @(posedge clk) begin
        if (byte_ok) begin
            case (phase)
                2'd0:    hold[7:0]  <= prog_data;
                2'd1:    hold[15:8] <= prog_data;
                default: hold       <= hold;
            endcase
        end
    end

    // third byte only carries bits 17:16
    always_ff @(posedge clk) begin
        if (word_wr) begin
            mem[ld_addr] <= {prog_data[1:0], hold};
        end
    end

    // registered fetch, one cycle after iaddr
    always_ff @(posedge clk) begin
        idata <= mem[iaddr];
    end

endmodule

/* hw/cheat_sdram_arb.sv */
`timescale 1ns/100ps

module cheat_sdram_arb (
    input  logic                  clk,
    input  logic                  prst,
    // game requester, has priority
    input  cheat_pkg::sdram_req_t game_req,
    output cheat_pkg::sdram_rsp_t game_rsp,
    // cheat requester
    input  cheat_pkg::sdram_req_t cheat_req,
    output cheat_pkg::sdram_rsp_t cheat_rsp,
    output logic                  owner_cheat,
    // towards the bank
    output cheat_pkg::sdram_req_t bank_req,
    input  cheat_pkg::sdram_rsp_t bank_rsp
);

    cheat_pkg::arb_state_t state_q;
    cheat_pkg::arb_state_t state_d;

    logic game_want;
    logic cheat_want;

    assign game_want  = game_req.rd  | game_req.wr;
    assign cheat_want = cheat_req.rd | cheat_req.wr;

    // requests are only looked at while idle
    always_comb begin
        state_d = state_q;
        case (state_q)
            cheat_pkg::idle: begin
                if (game_want)
                    state_d = cheat_pkg::game_busy;
                else if (cheat_want)
                    state_d = cheat_pkg::cheat_busy;
            end
            cheat_pkg::game_busy,
            cheat_pkg::cheat_busy: begin
                if (bank_rsp.rdy) state_d = cheat_pkg::idle;   // access over
            end
            default: state_d = cheat_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (prst) begin
            state_q <= cheat_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign owner_cheat = state_q == cheat_pkg::cheat_busy;

    // owner drives the bank, the other side sees zeros
    always_comb begin
        bank_req  = '0;
        game_rsp  = '0;
        cheat_rsp = '0;
        case (state_q)
            cheat_pkg::game_busy: begin
                bank_req = game_req;
                game_rsp = bank_rsp;
            end
            cheat_pkg::cheat_busy: begin
                bank_req  = cheat_req;
                cheat_rsp = bank_rsp;
            end
            default: begin
                bank_req = '0;   // nothing reaches the bank while idle
            end
        endcase
    end

endmodule

/* hw/cheat_top.sv */
`timescale 1ns/100ps

module cheat_top #(
    parameter int prog_aw = 10
) (
    input  logic                   clk,
    input  logic                   prst,
    input  logic                   lvbl,
    input  logic [31:0]            flags,
    // game side
    input  cheat_pkg::sdram_req_t  game_req,
    output cheat_pkg::sdram_rsp_t  game_rsp,
    // bank side, bank_data is also read by the game directly
    output cheat_pkg::sdram_req_t  bank_req,
    input  cheat_pkg::sdram_rsp_t  bank_rsp,
    input  cheat_pkg::sdram_data_t bank_data,
    // controller port bus
    input  cheat_pkg::port_id_t    port_id,
    input  cheat_pkg::port_data_t  out_data,
    input  logic                   wr_stb,
    input  logic                   k_wr_stb,
    input  logic                   rd_stb,
    output cheat_pkg::port_data_t  in_data,
    // controller interrupt, reset and fetch
    input  logic                   iack,
    output logic                   irq,
    output logic                   cpu_rst,
    input  logic [prog_aw-1:0]     iaddr,
    output cheat_pkg::instr_t      idata,
    // program loader
    input  logic                   prog_en,
    input  logic                   prog_wr,
    input  cheat_pkg::port_data_t  prog_data,
    output logic                   led
);

    cheat_pkg::sdram_req_t cheat_req;
    cheat_pkg::sdram_rsp_t cheat_rsp;
    logic                  owner_cheat;

    cheat_prog_rom #(
        .prog_aw   (prog_aw)
    ) rom_i (
        .clk       (clk),
        .prst      (prst),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_data (prog_data),
        .iaddr     (iaddr),
        .idata     (idata)
    );

    cheat_port_regs regs_i (
        .clk         (clk),
        .prst        (prst),
        .lvbl        (lvbl),
        .flags       (flags),
        .port_id     (port_id),
        .out_data    (out_data),
        .wr_stb      (wr_stb),
        .k_wr_stb    (k_wr_stb),
        .rd_stb      (rd_stb),
        .iack        (iack),
        .in_data     (in_data),
        .irq         (irq),
        .led         (led),
        .cpu_rst     (cpu_rst),
        .cheat_req   (cheat_req),
        .cheat_rsp   (cheat_rsp),
        .rd_data     (bank_data),
        .owner_cheat (owner_cheat)
    );

    cheat_sdram_arb arb_i (
        .clk         (clk),
        .prst        (prst),
        .game_req    (game_req),
        .game_rsp    (game_rsp),
        .cheat_req   (cheat_req),
        .cheat_rsp   (cheat_rsp),
        .owner_cheat (owner_cheat),
        .bank_req    (bank_req),
        .bank_rsp    (bank_rsp)
    );

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then decide on the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --Wno-fatal -f compile.f --top-module cheat_tb \
    -o cheat_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/cheat_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation PASSED"
exit 0
